//--- common/arya_cfg_pkg.sv
`default_nettype none

package arya_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // datapath sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned data_w      = 64;
    localparam int unsigned inst_w      = 32;
    localparam int unsigned reg_addr_w  = 5;
    localparam int unsigned mem_addr_w  = 10;
    localparam int unsigned inst_addr_w = 9;
    localparam int unsigned num_regs    = 32;
    localparam int unsigned mem_words   = 1024;

    // upper half of the unified memory is data
    localparam int unsigned data_region_bit = inst_addr_w;

    typedef logic [data_w-1:0]      word_t;
    typedef logic [reg_addr_w-1:0]  reg_idx_t;
    typedef logic [mem_addr_w-1:0]  mem_addr_t;
    typedef logic [inst_addr_w-1:0] pc_t;
    typedef logic [inst_w-1:0]      inst_t;

    // data word address: region bit forced high, low bits of the alu result
    function automatic mem_addr_t to_data_addr(input word_t result);
        return {1'b1, result[data_region_bit-1:0]};
    endfunction

endpackage

`default_nettype wire

//--- common/arya_isa_pkg.sv
`default_nettype none

package arya_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned op_msb  = 31;
    localparam int unsigned op_lsb  = 28;
    localparam int unsigned ra_msb  = 27;
    localparam int unsigned ra_lsb  = 23;
    localparam int unsigned rb_msb  = 22;
    localparam int unsigned rb_lsb  = 18;
    // rd overlaps imm16, only register forms use it
    localparam int unsigned rd_msb  = 17;
    localparam int unsigned rd_lsb  = 13;
    localparam int unsigned imm_msb = 15;
    localparam int unsigned imm_lsb = 0;
    localparam int unsigned off_msb = 8;
    localparam int unsigned off_lsb = 0;

    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_add   = 4'd1,
        op_sub   = 4'd2,
        op_and   = 4'd3,
        op_or    = 4'd4,
        op_xor   = 4'd5,
        op_addi  = 4'd6,
        op_load  = 4'd7,
        op_store = 4'd8,
        op_beq   = 4'd9,
        op_bne   = 4'd10
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4
    } alu_op_e;

endpackage

`default_nettype wire

//--- core/fetch_unit.sv
`default_nettype none

module fetch_unit
    import arya_cfg_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic branch_taken,
    input  pc_t  branch_target,
    output pc_t  fetch_pc,
    output pc_t  decode_pc
);

    pc_t pc;

    // redirect comes from the memory stage
    // pc wraps at 512 by width
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (en) begin
            if (branch_taken) begin
                pc <= branch_target;
            end else begin
                pc <= pc + pc_t'(1);
            end
        end
    end

    assign fetch_pc = pc;

    // pc travels alongside the memory read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decode_pc <= '0;
        end else if (en) begin
            decode_pc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- core/decode_stage.sv
`default_nettype none

module decode_stage
    import arya_cfg_pkg::*;
    import arya_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  inst_t    fetch_inst,
    input  pc_t      decode_pc,
    input  logic     wb_en,
    input  reg_idx_t wb_addr,
    input  word_t    wb_data,
    output word_t    ex_a,
    output word_t    ex_b,
    output word_t    ex_store_data,
    output alu_op_e  ex_alu_op,
    output pc_t      ex_pc,
    output pc_t      ex_offset,
    output reg_idx_t ex_dest,
    output logic     ex_wr_en,
    output logic     ex_mem_to_reg,
    output logic     ex_mem_write,
    output logic     ex_beq,
    output logic     ex_bne
);

    // instruction fields
    opcode_e  opcode;
    reg_idx_t ra;
    reg_idx_t rb;
    reg_idx_t rd;
    word_t    imm;
    pc_t      offset;

    // decoded controls
    logic     fetch_valid;
    logic     use_imm;
    logic     dec_wr_en;
    logic     dec_mem_to_reg;
    logic     dec_mem_write;
    logic     dec_beq;
    logic     dec_bne;
    alu_op_e  dec_alu_op;
    reg_idx_t dec_dest;

    // register file
    word_t    regs [num_regs];
    word_t    rf_a;
    word_t    rf_b;

    assign opcode = opcode_e'(fetch_inst[op_msb:op_lsb]);
    assign ra     = fetch_inst[ra_msb:ra_lsb];
    assign rb     = fetch_inst[rb_msb:rb_lsb];
    assign rd     = fetch_inst[rd_msb:rd_lsb];
    assign offset = fetch_inst[off_msb:off_lsb];
    // imm16 sign extended to the datapath
    assign imm    = {{(data_w - (imm_msb - imm_lsb + 1)){fetch_inst[imm_msb]}},
                     fetch_inst[imm_msb:imm_lsb]};

    ////////////////////////////////////////////////////////////////////////////
    // control decode
    ////////////////////////////////////////////////////////////////////////////

    // memory output register is empty until the first enabled fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else if (en) begin
            fetch_valid <= 1'b1;
        end
    end

    always_comb begin
        use_imm        = 1'b0;
        dec_wr_en      = 1'b0;
        dec_mem_to_reg = 1'b0;
        dec_mem_write  = 1'b0;
        dec_beq        = 1'b0;
        dec_bne        = 1'b0;
        dec_alu_op     = alu_add;
        dec_dest       = rd;
        // anything before that decodes as a nop
        if (fetch_valid) begin
            case (opcode)
                op_add: begin
                    dec_wr_en  = 1'b1;
                end
                op_sub: begin
                    dec_wr_en  = 1'b1;
                    dec_alu_op = alu_sub;
                end
                op_and: begin
                    dec_wr_en  = 1'b1;
                    dec_alu_op = alu_and;
                end
                op_or: begin
                    dec_wr_en  = 1'b1;
                    dec_alu_op = alu_or;
                end
                op_xor: begin
                    dec_wr_en  = 1'b1;
                    dec_alu_op = alu_xor;
                end
                // immediate forms write rb
                op_addi: begin
                    use_imm   = 1'b1;
                    dec_wr_en = 1'b1;
                    dec_dest  = rb;
                end
                op_load: begin
                    use_imm        = 1'b1;
                    dec_wr_en      = 1'b1;
                    dec_mem_to_reg = 1'b1;
                    dec_dest       = rb;
                end
                // address ra + imm, data from rb
                op_store: begin
                    use_imm       = 1'b1;
                    dec_mem_write = 1'b1;
                end
                // compare by subtract, zero flag in execute
                op_beq: begin
                    dec_alu_op = alu_sub;
                    dec_beq    = 1'b1;
                end
                op_bne: begin
                    dec_alu_op = alu_sub;
                    dec_bne    = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // register file, write before read
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (en && wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // bypass the writeback value in its own cycle
    assign rf_a = (wb_en && wb_addr == ra) ? wb_data : regs[ra];
    assign rf_b = (wb_en && wb_addr == rb) ? wb_data : regs[rb];

    ////////////////////////////////////////////////////////////////////////////
    // decode-execute register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_wr_en      <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_beq        <= 1'b0;
            ex_bne        <= 1'b0;
        end else if (en) begin
            ex_wr_en      <= dec_wr_en;
            ex_mem_to_reg <= dec_mem_to_reg;
            ex_mem_write  <= dec_mem_write;
            ex_beq        <= dec_beq;
            ex_bne        <= dec_bne;
        end
    end

    // operands and tags
    always_ff @(posedge clk) begin
        if (en) begin
            ex_a          <= rf_a;
            ex_b          <= use_imm ? imm : rf_b;
            ex_store_data <= rf_b;
            ex_alu_op     <= dec_alu_op;
            ex_pc         <= decode_pc;
            ex_offset     <= offset;
            ex_dest       <= dec_dest;
        end
    end

endmodule

`default_nettype wire

//--- core/execute_stage.sv
`default_nettype none

module execute_stage
    import arya_cfg_pkg::*;
    import arya_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en,
    input  word_t     ex_a,
    input  word_t     ex_b,
    input  word_t     ex_store_data,
    input  alu_op_e   ex_alu_op,
    input  pc_t       ex_pc,
    input  pc_t       ex_offset,
    input  reg_idx_t  ex_dest,
    input  logic      ex_wr_en,
    input  logic      ex_mem_to_reg,
    input  logic      ex_mem_write,
    input  logic      ex_beq,
    input  logic      ex_bne,
    output mem_addr_t data_addr,
    output word_t     data_wdata,
    output logic      data_we,
    output logic      branch_taken,
    output pc_t       branch_target,
    output word_t     mem_result,
    output reg_idx_t  mem_dest,
    output logic      mem_wr_en,
    output logic      mem_to_reg
);

    word_t alu_result;
    logic  alu_zero;
    pc_t   target;

    // execute-memory branch state
    logic  em_beq;
    logic  em_bne;
    logic  em_zero;
    pc_t   em_target;

    ////////////////////////////////////////////////////////////////////////////
    // alu and branch adder
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ex_alu_op)
            alu_sub: alu_result = ex_a - ex_b;
            alu_and: alu_result = ex_a & ex_b;
            alu_or:  alu_result = ex_a | ex_b;
            alu_xor: alu_result = ex_a ^ ex_b;
            default: alu_result = ex_a + ex_b;
        endcase
    end

    assign alu_zero = (alu_result == '0);

    // wraps modulo 512
    assign target = ex_pc + ex_offset;

    // access leaves straight from the alu
    // memory answers aligned with the execute-memory register
    assign data_addr  = to_data_addr(alu_result);
    assign data_wdata = ex_store_data;
    assign data_we    = ex_mem_write;

    ////////////////////////////////////////////////////////////////////////////
    // execute-memory register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wr_en  <= 1'b0;
            mem_to_reg <= 1'b0;
            em_beq     <= 1'b0;
            em_bne     <= 1'b0;
        end else if (en) begin
            mem_wr_en  <= ex_wr_en;
            mem_to_reg <= ex_mem_to_reg;
            em_beq     <= ex_beq;
            em_bne     <= ex_bne;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            mem_result <= alu_result;
            mem_dest   <= ex_dest;
            em_zero    <= alu_zero;
            em_target  <= target;
        end
    end

    // resolved in the memory stage, pc loads at the end of it
    assign branch_taken  = (em_beq && em_zero) || (em_bne && !em_zero);
    assign branch_target = em_target;

endmodule

`default_nettype wire

//--- core/writeback_stage.sv
`default_nettype none

module writeback_stage
    import arya_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  word_t    mem_result,
    input  word_t    data_rdata,
    input  reg_idx_t mem_dest,
    input  logic     mem_wr_en,
    input  logic     mem_to_reg,
    output logic     wb_en,
    output reg_idx_t wb_addr,
    output word_t    wb_data
);

    word_t mw_result;
    word_t mw_rdata;
    logic  mw_to_reg;

    // memory-writeback register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en     <= 1'b0;
            mw_to_reg <= 1'b0;
        end else if (en) begin
            wb_en     <= mem_wr_en;
            mw_to_reg <= mem_to_reg;
        end
    end

    // load data arrives with the execute-memory register
    always_ff @(posedge clk) begin
        if (en) begin
            mw_result <= mem_result;
            mw_rdata  <= data_rdata;
            wb_addr   <= mem_dest;
        end
    end

    // loads take the memory word, the rest the alu result
    assign wb_data = mw_to_reg ? mw_rdata : mw_result;

endmodule

`default_nettype wire

//--- rtl/unified_mem.sv
`default_nettype none

module unified_mem
    import arya_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      en,
    input  logic      setup_mem,
    input  logic      verify_mem,
    input  pc_t       fetch_pc,
    output inst_t     fetch_inst,
    input  mem_addr_t data_addr,
    input  word_t     data_wdata,
    input  logic      data_we,
    output word_t     data_rdata,
    input  mem_addr_t host_addr,
    input  word_t     host_wdata,
    output word_t     host_rdata
);

    word_t     mem [mem_words];

    // port b after arbitration
    mem_addr_t b_addr;
    word_t     b_wdata;
    logic      b_we;

    ////////////////////////////////////////////////////////////////////////////
    // port a, instruction fetch from the lower half
    ////////////////////////////////////////////////////////////////////////////

    // held while frozen so decode still sees the word of decode_pc
    always_ff @(posedge clk) begin
        if (en) begin
            fetch_inst <= mem[{1'b0, fetch_pc}][inst_w-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // port b, core data stage when running, host when halted
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (en) begin
            b_addr  = data_addr;
            b_wdata = data_wdata;
            b_we    = data_we;
        end else begin
            // host strobes only count while halted
            b_addr  = host_addr;
            b_wdata = host_wdata;
            b_we    = setup_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (b_we) begin
            mem[b_addr] <= b_wdata;
        end
    end

    // read result steered to its owner
    // each copy holds until its owner reads again
    always_ff @(posedge clk) begin
        if (en) begin
            data_rdata <= mem[b_addr];
        end else if (verify_mem) begin
            host_rdata <= mem[b_addr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/arya_top.sv
`default_nettype none

module arya_top
    import arya_cfg_pkg::*;
    import arya_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en,
    input  logic      setup_mem,
    input  logic      verify_mem,
    input  mem_addr_t mem_addr_in,
    input  word_t     mem_data_in,
    output word_t     mem_data_out
);

    ////////////////////////////////////////////////////////////////////////////
    // inter-stage wires, named after the driver
    ////////////////////////////////////////////////////////////////////////////

    // fetch
    pc_t       fetch_pc;
    pc_t       decode_pc;
    inst_t     fetch_inst;

    // decode-execute register
    word_t     ex_a;
    word_t     ex_b;
    word_t     ex_store_data;
    alu_op_e   ex_alu_op;
    pc_t       ex_pc;
    pc_t       ex_offset;
    reg_idx_t  ex_dest;
    logic      ex_wr_en;
    logic      ex_mem_to_reg;
    logic      ex_mem_write;
    logic      ex_beq;
    logic      ex_bne;

    // execute toward memory port b and fetch
    mem_addr_t data_addr;
    word_t     data_wdata;
    logic      data_we;
    word_t     data_rdata;
    logic      branch_taken;
    pc_t       branch_target;

    // execute-memory register
    word_t     mem_result;
    reg_idx_t  mem_dest;
    logic      mem_wr_en;
    logic      mem_to_reg;

    // register write back into decode
    logic      wb_en;
    reg_idx_t  wb_addr;
    word_t     wb_data;

    ////////////////////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////////////////////

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .fetch_pc      (fetch_pc),
        .decode_pc     (decode_pc)
    );

    decode_stage u_decode_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .fetch_inst    (fetch_inst),
        .decode_pc     (decode_pc),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_store_data (ex_store_data),
        .ex_alu_op     (ex_alu_op),
        .ex_pc         (ex_pc),
        .ex_offset     (ex_offset),
        .ex_dest       (ex_dest),
        .ex_wr_en      (ex_wr_en),
        .ex_mem_to_reg (ex_mem_to_reg),
        .ex_mem_write  (ex_mem_write),
        .ex_beq        (ex_beq),
        .ex_bne        (ex_bne)
    );

    execute_stage u_execute_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_store_data (ex_store_data),
        .ex_alu_op     (ex_alu_op),
        .ex_pc         (ex_pc),
        .ex_offset     (ex_offset),
        .ex_dest       (ex_dest),
        .ex_wr_en      (ex_wr_en),
        .ex_mem_to_reg (ex_mem_to_reg),
        .ex_mem_write  (ex_mem_write),
        .ex_beq        (ex_beq),
        .ex_bne        (ex_bne),
        .data_addr     (data_addr),
        .data_wdata    (data_wdata),
        .data_we       (data_we),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .mem_result    (mem_result),
        .mem_dest      (mem_dest),
        .mem_wr_en     (mem_wr_en),
        .mem_to_reg    (mem_to_reg)
    );

    writeback_stage u_writeback_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .mem_result (mem_result),
        .data_rdata (data_rdata),
        .mem_dest   (mem_dest),
        .mem_wr_en  (mem_wr_en),
        .mem_to_reg (mem_to_reg),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    // host side of port b is the top-level memory interface
    unified_mem u_unified_mem (
        .clk        (clk),
        .en         (en),
        .setup_mem  (setup_mem),
        .verify_mem (verify_mem),
        .fetch_pc   (fetch_pc),
        .fetch_inst (fetch_inst),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata),
        .host_addr  (mem_addr_in),
        .host_wdata (mem_data_in),
        .host_rdata (mem_data_out)
    );

endmodule

`default_nettype wire

//--- tests/tb_arya.sv
`default_nettype none

module tb_arya
    import arya_cfg_pkg::*;
    import arya_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////////////////////
    // run lengths and program layout
    ////////////////////////////////////////////////////////////////////////////

    localparam int n_body     = 40;
    localparam int n_programs = 6;
    localparam int n_host     = 64;
    // every instruction sits in a slot with four nops behind it
    localparam int slot_w     = 5;
    localparam int halt_slot  = n_body + num_regs;
    localparam int prog_words = (halt_slot + 1) * slot_w;
    localparam int run_limit  = prog_words * 4;
    localparam int clk_period = 40;
    localparam int timeout_cycles = n_programs * (prog_words * 5 + 200);
    localparam logic [31:0] seed = 32'h20b4_747b;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      en;
    logic      setup_mem;
    logic      verify_mem;
    mem_addr_t mem_addr_in;
    word_t     mem_data_in;
    word_t     mem_data_out;

    // reference state
    logic [31:0] lfsr;
    word_t       model_mem [mem_words];
    word_t       prog [prog_words];
    mem_addr_t   check_addr [mem_words];
    int          n_check;
    int          checks;
    int          errors;

    arya_top u_arya_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .setup_mem    (setup_mem),
        .verify_mem   (verify_mem),
        .mem_addr_in  (mem_addr_in),
        .mem_data_in  (mem_data_in),
        .mem_data_out (mem_data_out)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////////////////////

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic word_t rand_bits(input int unsigned n);
        word_t v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            v    = {v[data_w-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoding
    ////////////////////////////////////////////////////////////////////////////

    function automatic inst_t enc_reg(input opcode_e op, input reg_idx_t ra,
                                      input reg_idx_t rb, input reg_idx_t rd);
        return {op, ra, rb, rd, 13'd0};
    endfunction

    function automatic inst_t enc_imm(input opcode_e op, input reg_idx_t ra,
                                      input reg_idx_t rb, input logic [15:0] imm);
        return {op, ra, rb, 2'b00, imm};
    endfunction

    function automatic inst_t enc_branch(input opcode_e op, input reg_idx_t ra,
                                         input reg_idx_t rb, input pc_t off);
        return {op, ra, rb, 9'd0, off};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // host port
    ////////////////////////////////////////////////////////////////////////////

    task automatic host_write(input mem_addr_t addr, input word_t data);
        @(posedge clk);
        setup_mem   <= 1'b1;
        mem_addr_in <= addr;
        mem_data_in <= data;
        model_mem[addr] = data;
    endtask

    task automatic host_idle();
        @(posedge clk);
        setup_mem  <= 1'b0;
        verify_mem <= 1'b0;
    endtask

    task automatic check_word(input mem_addr_t addr);
        checks++;
        if (mem_data_out !== model_mem[addr]) begin
            errors++;
            $display("error: %0t ns mem_data_out at address %03h expected %h got %h",
                     $time, addr, model_mem[addr], mem_data_out);
        end
    endtask

    // one read per cycle, each answer checked a cycle after its request
    task automatic read_back();
        for (int i = 0; i <= n_check; i++) begin
            @(posedge clk);
            if (i < n_check) begin
                verify_mem  <= 1'b1;
                mem_addr_in <= check_addr[i];
            end else begin
                verify_mem <= 1'b0;
            end
            if (i > 0) begin
                @(negedge clk);
                check_word(check_addr[i-1]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // program generation
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_program();
        int          i;
        int          t;
        opcode_e     op;
        reg_idx_t    ra;
        reg_idx_t    rb;
        reg_idx_t    rd;
        logic [15:0] imm;
        logic [15:0] base;
        for (int w = 0; w < prog_words; w++) begin
            prog[w] = '0;
        end
        i = 0;
        while (i < n_body) begin
            op  = opcode_e'(4'(rand_bits(4) % 10 + 1));
            ra  = reg_idx_t'(rand_bits(5));
            rb  = reg_idx_t'(rand_bits(5));
            rd  = reg_idx_t'(rand_bits(5));
            imm = 16'(rand_bits(16));
            // registers start at zero, seed some values first
            if (i < 8) begin
                op = op_addi;
            end
            case (op)
                op_addi, op_load: begin
                    prog[i*slot_w] = {32'd0, enc_imm(op, ra, rb, imm)};
                end
                op_store: begin
                    prog[i*slot_w] = {32'd0, enc_imm(op_store, ra, rb, imm)};
                    // same address read straight back into a random register
                    if (i + 1 < n_body) begin
                        i++;
                        prog[i*slot_w] = {32'd0, enc_imm(op_load, ra,
                                          reg_idx_t'(rand_bits(5)), imm)};
                    end
                end
                op_beq, op_bne: begin
                    // forward only, skips zero to three slots
                    t = i + 1 + int'(rand_bits(2));
                    if (t > n_body) begin
                        t = n_body;
                    end
                    prog[i*slot_w] = {32'd0, enc_branch(op, ra, rb,
                                      pc_t'((t - i) * slot_w))};
                end
                default: begin
                    prog[i*slot_w] = {32'd0, enc_reg(op, ra, rb, rd)};
                end
            endcase
            i++;
        end
        // register dump at r0 plus a random base, one word per register
        base = 16'(rand_bits(16));
        for (int r = 0; r < num_regs; r++) begin
            prog[(n_body + r) * slot_w] = {32'd0, enc_imm(op_store, '0,
                                           reg_idx_t'(r), base + 16'(r))};
        end
        // branch to self
        prog[halt_slot * slot_w] = {32'd0, enc_branch(op_beq, '0, '0, '0)};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // instruction-set model, one instruction at a time
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_model();
        word_t    r [num_regs];
        inst_t    w;
        pc_t      pc;
        pc_t      next_pc;
        reg_idx_t ra;
        reg_idx_t rb;
        reg_idx_t rd;
        word_t    imm;
        word_t    sum;
        int       steps;
        for (int k = 0; k < num_regs; k++) begin
            r[k] = '0;
        end
        pc    = '0;
        steps = 0;
        while (pc != pc_t'(halt_slot * slot_w) && steps < prog_words) begin
            w       = model_mem[{1'b0, pc}][31:0];
            ra      = w[ra_msb:ra_lsb];
            rb      = w[rb_msb:rb_lsb];
            rd      = w[rd_msb:rd_lsb];
            imm     = {{48{w[15]}}, w[15:0]};
            sum     = r[ra] + imm;
            next_pc = pc + 1'b1;
            case (opcode_e'(w[op_msb:op_lsb]))
                op_add:  r[rd] = r[ra] + r[rb];
                op_sub:  r[rd] = r[ra] - r[rb];
                op_and:  r[rd] = r[ra] & r[rb];
                op_or:   r[rd] = r[ra] | r[rb];
                op_xor:  r[rd] = r[ra] ^ r[rb];
                op_addi: r[rb] = sum;
                // data word lives in the upper half
                op_load:  r[rb] = model_mem[{1'b1, sum[8:0]}];
                op_store: model_mem[{1'b1, sum[8:0]}] = r[rb];
                op_beq: begin
                    if (r[ra] == r[rb]) begin
                        next_pc = pc + w[8:0];
                    end
                end
                op_bne: begin
                    if (r[ra] != r[rb]) begin
                        next_pc = pc + w[8:0];
                    end
                end
                default: begin
                end
            endcase
            pc = next_pc;
            steps++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // core runs
    ////////////////////////////////////////////////////////////////////////////

    // program goes in while the core sits in reset
    task automatic load_program();
        @(posedge clk);
        en    <= 1'b0;
        rst_n <= 1'b0;
        for (int a = 0; a < prog_words; a++) begin
            host_write(mem_addr_t'(a), prog[a]);
        end
        host_idle();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_program(input logic interrupt, input int idx);
        int cycles;
        int gap;
        cycles = 0;
        gap    = 0;
        @(posedge clk);
        en <= 1'b1;
        forever begin
            @(negedge clk);
            // halt word reached at the fetch port
            if (en && u_arya_top.fetch_pc == pc_t'(halt_slot * slot_w)) begin
                break;
            end
            if (cycles >= run_limit) begin
                errors++;
                $display("program %0d did not reach its halt address within %0d cycles",
                         idx, run_limit);
                break;
            end
            @(posedge clk);
            cycles++;
            // random freeze stretches of one to eight cycles
            if (gap > 0) begin
                gap--;
                if (gap == 0) begin
                    en <= 1'b1;
                end
            end else if (interrupt && rand_bits(3) == 0) begin
                gap = int'(rand_bits(3)) + 1;
                en  <= 1'b0;
            end
        end
        // drain the last stores
        @(posedge clk);
        en <= 1'b1;
        repeat (8) @(posedge clk);
        en <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        lfsr        = seed;
        checks      = 0;
        errors      = 0;
        rst_n       = 1'b0;
        en          = 1'b0;
        setup_mem   = 1'b0;
        verify_mem  = 1'b0;
        mem_addr_in = '0;
        mem_data_in = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // host write and readback over the whole memory
        n_check = n_host;
        for (int k = 0; k < n_host; k++) begin
            check_addr[k] = mem_addr_t'(rand_bits(mem_addr_w));
            host_write(check_addr[k], rand_bits(data_w));
        end
        host_idle();
        read_back();

        // random data region contents for the loads
        for (int a = mem_words / 2; a < mem_words; a++) begin
            host_write(mem_addr_t'(a), rand_bits(data_w));
        end
        host_idle();

        // odd programs run with en dropping in between
        for (int p = 0; p < n_programs; p++) begin
            build_program();
            load_program();
            run_model();
            run_program(p[0], p);
            n_check = mem_words / 2;
            for (int k = 0; k < n_check; k++) begin
                check_addr[k] = mem_addr_t'(mem_words / 2 + k);
            end
            read_back();
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // limit scales with the program count and length
    initial begin
        #(timeout_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run is stuck", timeout_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
common/arya_cfg_pkg.sv
common/arya_isa_pkg.sv
core/fetch_unit.sv
core/decode_stage.sv
core/execute_stage.sv
core/writeback_stage.sv
rtl/unified_mem.sv
rtl/arya_top.sv
tests/tb_arya.sv

//--- Bender.yml
package:
  name: arya

sources:
  - common/arya_cfg_pkg.sv
  - common/arya_isa_pkg.sv
  - core/fetch_unit.sv
  - core/decode_stage.sv
  - core/execute_stage.sv
  - core/writeback_stage.sv
  - rtl/unified_mem.sv
  - rtl/arya_top.sv
  - target: test
    files:
      - tests/tb_arya.sv
